// ==== muldiv.f ====
src/muldiv_cfg_pkg.sv
src/muldiv_op_pkg.sv
src/muldiv_step_if.sv
src/muldiv_ctrl.sv
src/muldiv_datapath.sv
src/muldiv_top.sv
tb/muldiv_chk.sv
tb/muldiv_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the muldiv testbench with Verilator
verilator --binary --timing --assert -Wno-fatal -f muldiv.f --top-module muldiv_tb \
   -o muldiv_sim \
   && ./obj_dir/muldiv_sim | tee /dev/stderr | grep -qx "sim passed" \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }

// ==== src/muldiv_cfg_pkg.sv ====
// Muldiv width definitions
package muldiv_cfg_pkg;

   // Default operand width, one machine word
   localparam int unsigned DEF_WIDTH = 8;

   // Bits needed to count every iteration step
   localparam int unsigned CNT_W = $clog2(DEF_WIDTH + 1);

   // Operand, quotient, remainder or one half of a product
   typedef logic [DEF_WIDTH-1:0] word_t;

   // Iteration step counter
   typedef logic [CNT_W-1:0] count_t;

endpackage

// ==== src/muldiv_ctrl.sv ====
// Muldiv sequencer
`timescale 1ns/1ps

module muldiv_ctrl #(
   parameter int unsigned WIDTH = muldiv_cfg_pkg::DEF_WIDTH
) (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                req_valid,
   input  muldiv_op_pkg::op_e  req_op,
   output logic                result_valid,
   output logic                credit_return,
   muldiv_step_if.ctrl         step
);
   import muldiv_cfg_pkg::*;
   import muldiv_op_pkg::*;

   ctrl_state_e state;
   logic        credit;  // Requester credit is home
   count_t      count;   // Steps done in this run

   // Accept only with the credit home and the FSM idle
   assign step.load = req_valid && credit && (state == ST_IDLE);

   assign step.step = (state == ST_RUN);
   assign step.last = step.step && (count == count_t'(WIDTH - 1));

   // Result pulse and credit return share the DONE cycle
   assign result_valid  = (state == ST_DONE);
   assign credit_return = (state == ST_DONE);

   // FSM and credit
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state  <= ST_IDLE;
         credit <= 1'b1;
      end else begin
         case (state)
            ST_IDLE: begin
               if (step.load) begin
                  state  <= ST_RUN;
                  credit <= 1'b0;  // Spent by the request
               end
            end
            ST_RUN: begin
               if (step.last) begin
                  state <= ST_DONE;
               end
            end
            ST_DONE: begin
               state  <= ST_IDLE;
               credit <= 1'b1;  // Back with credit_return
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // Step counter
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         count <= '0;
      end else if (step.load) begin
         count <= '0;
      end else if (step.step) begin
         count <= count + 1'b1;
      end
   end

   // Operation latched at acceptance, steady through the run
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         step.mode <= OP_MUL;
      end else if (step.load) begin
         step.mode <= req_op;
      end
   end

endmodule

// ==== src/muldiv_datapath.sv ====
// Muldiv datapath
`timescale 1ns/1ps

module muldiv_datapath #(
   parameter int unsigned WIDTH = muldiv_cfg_pkg::DEF_WIDTH
) (
   input  logic                   clk,
   input  logic                   arst_n,
   input  muldiv_cfg_pkg::word_t  a,
   input  muldiv_cfg_pkg::word_t  b,
   output muldiv_cfg_pkg::word_t  hi,
   output muldiv_cfg_pkg::word_t  lo,
   muldiv_step_if.dp              step
);
   import muldiv_cfg_pkg::*;
   import muldiv_op_pkg::*;

   word_t        q_reg;     // Accumulator Q, product high half or remainder
   word_t        m_reg;     // Shift register M, multiplier then product low or quotient
   word_t        b_reg;     // Multiplicand or divisor
   logic         div_mode;
   word_t        add_a;     // Adder operand from Q
   word_t        add_b;     // Adder operand from B
   logic         add_cin;
   logic [WIDTH:0] add_sum; // Carry out on top
   logic         carry;
   logic         hold_q;    // Trial subtraction borrowed
   word_t        q_next;
   word_t        m_next;

   assign div_mode = (step.mode == OP_DIVU);

   // Shared adder/subtractor
   // Divide works on Q shifted left with the M msb entering at the bottom
   assign add_a   = div_mode ? {q_reg[WIDTH-2:0], m_reg[WIDTH-1]} : q_reg;
   assign add_b   = div_mode ? ~b_reg : (m_reg[0] ? b_reg : '0);  // Add B only on M lsb set
   assign add_cin = div_mode;                                     // Two's complement subtract
   assign add_sum = {1'b0, add_a} + {1'b0, add_b} + {{WIDTH{1'b0}}, add_cin};

   // Carry out of the word, or the bit shifted out of Q, means no borrow
   assign carry  = add_sum[WIDTH] | (div_mode & q_reg[WIDTH-1]);
   assign hold_q = div_mode & ~carry;

   // Step results
   always_comb begin
      if (div_mode) begin
         q_next = hold_q ? add_a : add_sum[WIDTH-1:0];  // Keep shifted Q on borrow
         m_next = {m_reg[WIDTH-2:0], ~hold_q};          // Quotient bit in at the bottom
      end else begin
         // Carry, Q and M move right as one register
         q_next = {carry, add_sum[WIDTH-1:1]};
         m_next = {add_sum[0], m_reg[WIDTH-1:1]};
      end
   end

   // Q and M
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         q_reg <= '0;
         m_reg <= '0;
      end else if (step.load) begin
         q_reg <= '0;  // Clear accumulator
         m_reg <= a;
      end else if (step.step) begin
         q_reg <= q_next;
         m_reg <= m_next;
      end
   end

   // Multiplicand or divisor, fixed for the run
   always_ff @(posedge clk) begin
      if (step.load) begin
         b_reg <= b;
      end
   end

   assign hi = q_reg;
   assign lo = m_reg;

endmodule

// ==== src/muldiv_op_pkg.sv ====
// Muldiv operation and state encodings
package muldiv_op_pkg;

   // Requested operation
   typedef enum logic {
      OP_MUL  = 1'b0,  // Unsigned shift-and-add multiply
      OP_DIVU = 1'b1   // Unsigned restoring division
   } op_e;

   // Sequencer states
   typedef enum logic [1:0] {
      ST_IDLE = 2'b00,  // Credit home, waiting for a request
      ST_RUN  = 2'b01,  // Iterating, one step per cycle
      ST_DONE = 2'b10   // Result pulse and credit return
   } ctrl_state_e;

endpackage

// ==== src/muldiv_step_if.sv ====
// Muldiv step control interface
`timescale 1ns/1ps

interface muldiv_step_if;
   import muldiv_op_pkg::*;

   logic load;  // Capture operands, one cycle at acceptance
   logic step;  // One iteration of the datapath
   op_e  mode;  // Operation held for the whole run
   logic last;  // Final iteration

   // Sequencer side
   modport ctrl (
      output load,
      output step,
      output mode,
      output last
   );

   // Datapath side, last is only used by the sequencer itself
   modport dp (
      input load,
      input step,
      input mode
   );

endinterface

// ==== src/muldiv_top.sv ====
// Muldiv top level
`timescale 1ns/1ps

module muldiv_top #(
   parameter int unsigned WIDTH = muldiv_cfg_pkg::DEF_WIDTH
) (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   req_valid,
   input  muldiv_op_pkg::op_e     req_op,
   input  muldiv_cfg_pkg::word_t  req_a,
   input  muldiv_cfg_pkg::word_t  req_b,
   output logic                   credit_return,
   output logic                   result_valid,
   output muldiv_cfg_pkg::word_t  result_hi,
   output muldiv_cfg_pkg::word_t  result_lo
);

   // Step control from sequencer to datapath
   muldiv_step_if step_if ();

   // Sequencer, owns the credit and the iteration count
   muldiv_ctrl #(
      .WIDTH (WIDTH)
   ) u_ctrl (
      .clk           (clk),
      .arst_n        (arst_n),
      .req_valid     (req_valid),
      .req_op        (req_op),
      .result_valid  (result_valid),
      .credit_return (credit_return),
      .step          (step_if.ctrl)
   );

   // Q, M and B with the shared adder
   muldiv_datapath #(
      .WIDTH (WIDTH)
   ) u_datapath (
      .clk    (clk),
      .arst_n (arst_n),
      .a      (req_a),
      .b      (req_b),
      .hi     (result_hi),  // Product high or remainder
      .lo     (result_lo),  // Product low or quotient
      .step   (step_if.dp)
   );

endmodule

// ==== tb/muldiv_chk.sv ====
// Muldiv handshake checker
`timescale 1ns/1ps

module muldiv_chk #(
   parameter int unsigned WIDTH = muldiv_cfg_pkg::DEF_WIDTH
) (
   input logic clk,
   input logic arst_n,
   input logic req_valid,
   input logic credit_return,
   input logic result_valid
);

   logic           credit_home;  // Requester credit as seen at the ports
   logic           accepted;
   logic [WIDTH:0] pending;      // Accepted requests in flight, one bit per cycle

   assign accepted = req_valid && credit_home;

   // Credit model
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         credit_home <= 1'b1;
      end else if (accepted) begin
         credit_home <= 1'b0;
      end else if (credit_return) begin
         credit_home <= 1'b1;  // Usable from the next cycle on
      end
   end

   // Delay line from the accepting edge to the result pulse
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pending <= '0;
      end else begin
         pending <= {pending[WIDTH-1:0], accepted};
      end
   end

   a_credit_with_result : assert property (@(posedge clk) disable iff (!arst_n)
      credit_return == result_valid)
      else $error("credit_return and result_valid differ");

   a_result_latency : assert property (@(posedge clk) disable iff (!arst_n)
      result_valid == pending[WIDTH])  // Exactly WIDTH+1 cycles after acceptance
      else $error("result_valid out of step with the accepted request");

   a_req_needs_credit : assert property (@(posedge clk) disable iff (!arst_n)
      req_valid |-> credit_home)
      else $error("req_valid raised while the credit is outstanding");

   a_quiet_in_reset : assert property (@(posedge clk)
      !arst_n |-> !result_valid)
      else $error("result_valid high during reset");

endmodule

bind muldiv_top muldiv_chk #(
   .WIDTH (WIDTH)
) u_chk (
   .clk           (clk),
   .arst_n        (arst_n),
   .req_valid     (req_valid),
   .credit_return (credit_return),
   .result_valid  (result_valid)
);

// ==== tb/muldiv_tb.sv ====
// Muldiv testbench
`timescale 1ns/1ps

module muldiv_tb;
   import muldiv_cfg_pkg::*;
   import muldiv_op_pkg::*;

   localparam int unsigned WIDTH     = 8;
   localparam int unsigned RESET_CYC = 10;
   localparam int unsigned N_RANDOM  = 200;
   localparam int unsigned N_OPS     = N_RANDOM + 40;  // Random mix plus directed cases
   localparam int unsigned LATENCY   = WIDTH + 1;      // Accepting edge to result_valid
   localparam int unsigned WDOG_CYC  = RESET_CYC + N_OPS * (WIDTH + 4) + 200;
   localparam logic [31:0] SEED      = 32'hb57bcd75;

   logic  clk;
   logic  arst_n;
   logic  req_valid;
   op_e   req_op;
   word_t req_a;
   word_t req_b;
   logic  credit_return;
   logic  result_valid;
   word_t result_hi;
   word_t result_lo;

   int unsigned checks;
   int unsigned errors;
   int          credits;  // Credits held on the requester side

   muldiv_top #(
      .WIDTH (WIDTH)
   ) dut (
      .clk           (clk),
      .arst_n        (arst_n),
      .req_valid     (req_valid),
      .req_op        (req_op),
      .req_a         (req_a),
      .req_b         (req_b),
      .credit_return (credit_return),
      .result_valid  (result_valid),
      .result_hi     (result_hi),
      .result_lo     (result_lo)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;  // 4 ns period
   end

   task automatic check_word(input string name, input word_t exp, input word_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act);
      end
   endtask

   task automatic check_latency(input int unsigned exp, input int unsigned act);
      checks++;
      if (exp != act) begin
         errors++;
         $display("[FAIL] result_valid latency expected 0x%0h actual 0x%0h", exp, act);
      end
   endtask

   // Arithmetic rules for both operations
   function automatic void expected_result(input op_e op, input word_t a, input word_t b,
                                           output word_t exp_hi, output word_t exp_lo);
      logic [2*WIDTH-1:0] prod;
      prod = {{WIDTH{1'b0}}, a} * {{WIDTH{1'b0}}, b};
      if (op == OP_MUL) begin
         exp_hi = prod[2*WIDTH-1:WIDTH];
         exp_lo = prod[WIDTH-1:0];
      end else if (b == '0) begin
         exp_hi = a;   // Remainder keeps the dividend
         exp_lo = '1;  // Every trial subtraction succeeds
      end else begin
         exp_hi = a % b;
         exp_lo = a / b;
      end
   endfunction

   // Called right after a rising edge and returns on the result edge
   task automatic run_op(input op_e op, input word_t a, input word_t b,
                         output word_t hi, output word_t lo, output int unsigned lat);
      lat = 0;
      hi  = '0;
      lo  = '0;
      if (credits < 1) begin
         errors++;
         $display("request sent with no credit held");
      end
      req_valid <= 1'b1;
      req_op    <= op;
      req_a     <= a;
      req_b     <= b;
      credits--;
      @(posedge clk);  // Accepting edge
      req_valid <= 1'b0;
      do begin
         @(posedge clk);
         lat++;
      end while (!result_valid && lat < LATENCY + 8);
      if (result_valid) begin
         hi = result_hi;
         lo = result_lo;
         check_bit("credit_return", 1'b1, credit_return);
         if (credit_return) begin
            credits++;  // Credit home again
         end
      end else begin
         errors++;
         $display("no result_valid within %0d cycles of the request", lat);
      end
   endtask

   task automatic do_op(input op_e op, input word_t a, input word_t b);
      word_t       hi;
      word_t       lo;
      word_t       exp_hi;
      word_t       exp_lo;
      int unsigned lat;
      expected_result(op, a, b, exp_hi, exp_lo);
      run_op(op, a, b, hi, lo, lat);
      check_word($sformatf("result_hi (%s 0x%h 0x%h)", op.name(), a, b), exp_hi, hi);
      check_word($sformatf("result_lo (%s 0x%h 0x%h)", op.name(), a, b), exp_lo, lo);
      check_latency(LATENCY, lat);
   endtask

   task automatic report_test(input string name, input int unsigned err0);
      $display("%-20s %s, %0d errors", name, (errors == err0) ? "ok" : "FAILED", errors - err0);
   endtask

   task automatic test_idle();
      int unsigned err0;
      err0 = errors;
      repeat (6) begin
         @(posedge clk);
         check_bit("result_valid", 1'b0, result_valid);
         check_bit("credit_return", 1'b0, credit_return);
      end
      report_test("idle after reset", err0);
   endtask

   task automatic test_mul_corners();
      int unsigned err0;
      int unsigned i;
      err0 = errors;
      do_op(OP_MUL, 8'h00, 8'ha7);  // Zero times x
      do_op(OP_MUL, 8'hc3, 8'h00);
      do_op(OP_MUL, 8'h01, 8'ha7);  // One times x
      do_op(OP_MUL, 8'hc3, 8'h01);
      do_op(OP_MUL, '1, '1);        // Largest product
      for (i = 0; i < WIDTH; i++) begin
         do_op(OP_MUL, word_t'(1) << i, 8'hb5);  // Walking power of two
      end
      do_op(OP_MUL, 8'h80, 8'h80);
      report_test("multiply corners", err0);
   endtask

   task automatic test_div_corners();
      int unsigned err0;
      err0 = errors;
      do_op(OP_DIVU, 8'hd3, 8'h01);  // x / 1
      do_op(OP_DIVU, 8'hff, 8'h01);
      do_op(OP_DIVU, 8'hc8, 8'hc8);  // x / x
      do_op(OP_DIVU, 8'h01, 8'h01);
      do_op(OP_DIVU, 8'h07, 8'h2b);  // Small over large
      do_op(OP_DIVU, 8'h0e, 8'hff);
      do_op(OP_DIVU, '1, 8'h03);     // Remainder zero
      do_op(OP_DIVU, 8'h00, 8'h05);
      report_test("divide corners", err0);
   endtask

   task automatic test_div_zero();
      int unsigned err0;
      err0 = errors;
      do_op(OP_DIVU, 8'h00, 8'h00);
      do_op(OP_DIVU, 8'h01, 8'h00);
      do_op(OP_DIVU, 8'h9c, 8'h00);
      do_op(OP_DIVU, '1, 8'h00);
      report_test("divide by zero", err0);
   endtask

   task automatic test_random_mix();
      int unsigned err0;
      int unsigned i;
      op_e         op;
      word_t       a;
      word_t       b;
      err0 = errors;
      for (i = 0; i < N_RANDOM; i++) begin
         op = ($urandom_range(1, 0) == 1) ? OP_DIVU : OP_MUL;
         a  = word_t'($urandom);
         b  = word_t'($urandom);
         if ($urandom_range(3, 0) == 0) begin
            b = word_t'($urandom_range(3, 0));  // Small divisors and zero
         end
         do_op(op, a, b);  // Sent on the credit_return edge
      end
      report_test("random mix", err0);
   endtask

   // Watchdog
   initial begin
      repeat (WDOG_CYC) @(posedge clk);
      $display("watchdog expired after %0d cycles", WDOG_CYC);
      $display("sim failed");
      $finish;
   end

   initial begin
      void'($urandom(SEED));
      checks    = 0;
      errors    = 0;
      credits   = 0;
      arst_n    = 1'b0;
      req_valid = 1'b0;
      req_op    = OP_MUL;
      req_a     = '0;
      req_b     = '0;
      repeat (RESET_CYC) @(posedge clk);
      arst_n  <= 1'b1;
      credits = 1;  // One credit after reset
      test_idle();
      test_mul_corners();
      test_div_corners();
      test_div_zero();
      test_random_mix();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule
